//--- hdl/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// cpu address and data widths
`define DC_ADDR_W 32
`define DC_WORD_W 64
`define DC_STRB_W 8

// two ways of 64 sets, one word per line
`define DC_SETS 64

// address split: [31:9] tag, [8:3] index, [2:0] byte offset
`define DC_INDEX_LSB 3
`define DC_INDEX_MSB 8
`define DC_TAG_LSB 9
`define DC_TAG_W 23

`endif

//--- hdl/dcache_pkg.sv
`default_nettype none

`include "dcache_defs.svh"

package dcache_pkg;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        HIT,
        WBACK,
        REFILL
    } dc_state_e;

    // cache geometry
    typedef logic [`DC_INDEX_MSB-`DC_INDEX_LSB:0] dc_index_t;
    typedef logic [`DC_TAG_W-1:0] dc_tag_t;
    typedef logic [0:0] dc_way_t;

endpackage

`default_nettype wire

//--- hdl/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // memory side operation, held until mem_ready_i
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_REFILL,
        MEM_WBACK
    } mem_op_e;

endpackage

`default_nettype wire

//--- hdl/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_tag_store
    import dcache_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n_i,
    input  wire dc_index_t index_i,
    input  wire dc_tag_t   tag_i,
    input  wire            fill_i,
    input  wire dc_way_t   fill_way_i,
    input  wire            set_dirty_i,
    input  wire            touch_i,
    input  wire dc_way_t   use_way_i,
    output logic           hit_o,
    output dc_way_t        hit_way_o,
    output dc_way_t        victim_way_o,
    output logic           victim_dirty_o,
    output dc_tag_t        victim_tag_o
);

    dc_tag_t             tag_q [2][`DC_SETS];
    logic [`DC_SETS-1:0] valid_q [2];
    logic [`DC_SETS-1:0] dirty_q [2];
    // set bit points at the way used last
    logic [`DC_SETS-1:0] ru_q;
    logic [1:0]          way_valid;
    logic [1:0]          way_hit;

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_valid[w] = valid_q[w][index_i];
            way_hit[w]   = way_valid[w] && (tag_q[w][index_i] == tag_i);
        end
    end

    assign hit_o     = |way_hit;
    assign hit_way_o = way_hit[1];

    // empty way first, then the one not used last
    always_comb begin
        if (!way_valid[0]) begin
            victim_way_o = 1'b0;
        end else if (!way_valid[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = ~ru_q[index_i];
        end
    end

    assign victim_dirty_o = dirty_q[victim_way_o][index_i];
    assign victim_tag_o   = tag_q[victim_way_o][index_i];

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[fill_way_i][index_i] <= tag_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '{default: '0};
            dirty_q <= '{default: '0};
            ru_q    <= '0;
        end else begin
            if (fill_i) begin
                valid_q[fill_way_i][index_i] <= 1'b1;
                dirty_q[fill_way_i][index_i] <= 1'b0;
            end
            if (set_dirty_i) begin
                dirty_q[use_way_i][index_i] <= 1'b1;
            end
            if (touch_i) begin
                ru_q[index_i] <= use_way_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/dcache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_data_store
    import dcache_pkg::*;
(
    input  wire                   clk,
    input  wire dc_index_t        index_i,
    input  wire                   we_i,
    input  wire dc_way_t          way_i,
    input  wire [`DC_STRB_W-1:0]  wstrb_i,
    input  wire [`DC_WORD_W-1:0]  wdata_i,
    output logic [`DC_WORD_W-1:0] rdata0_o,
    output logic [`DC_WORD_W-1:0] rdata1_o
);

    logic [`DC_WORD_W-1:0] mem_q [2][`DC_SETS];

    // byte-masked write into the chosen way
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < `DC_STRB_W; b++) begin
                if (wstrb_i[b]) begin
                    mem_q[way_i][index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // both ways read every cycle, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdata0_o <= mem_q[0][index_i];
        rdata1_o <= mem_q[1][index_i];
    end

endmodule

`default_nettype wire

//--- hdl/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_ctrl
    import dcache_pkg::*;
    import mem_bus_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   req_valid_i,
    input  wire                   req_write_i,
    input  wire [`DC_ADDR_W-1:0]  addr_i,
    input  wire [`DC_WORD_W-1:0]  wdata_i,
    input  wire [`DC_STRB_W-1:0]  wstrb_i,
    output logic [`DC_WORD_W-1:0] rdata_o,
    output logic                  done_o,
    output mem_op_e               mem_op_o,
    output logic [`DC_ADDR_W-1:0] mem_addr_o,
    output logic [`DC_WORD_W-1:0] mem_wdata_o,
    input  wire [`DC_WORD_W-1:0]  mem_rdata_i,
    input  wire                   mem_ready_i,
    output logic                  fill_o,
    output dc_way_t               fill_way_o,
    output logic                  set_dirty_o,
    output logic                  touch_o,
    output dc_way_t               use_way_o,
    output dc_index_t             index_o,
    output dc_tag_t               tag_o,
    output logic                  ram_we_o,
    output dc_way_t               ram_way_o,
    output logic [`DC_STRB_W-1:0] ram_wstrb_o,
    output logic [`DC_WORD_W-1:0] ram_wdata_o,
    input  wire                   hit_i,
    input  wire dc_way_t          hit_way_i,
    input  wire dc_way_t          victim_way_i,
    input  wire                   victim_dirty_i,
    input  wire dc_tag_t          victim_tag_i,
    input  wire [`DC_WORD_W-1:0]  rdata0_i,
    input  wire [`DC_WORD_W-1:0]  rdata1_i
);

    dc_state_e             state_q;
    dc_state_e             state_d;
    logic                  in_hit;
    logic                  refill_done;
    logic [`DC_WORD_W-1:0] victim_word;

    // request is held by the cpu, so the index stays put
    assign tag_o   = addr_i[`DC_ADDR_W-1:`DC_TAG_LSB];
    assign index_o = addr_i[`DC_INDEX_MSB:`DC_INDEX_LSB];

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (req_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i) begin
                    state_d = HIT;
                end else if (victim_dirty_i) begin
                    state_d = WBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WBACK: begin
                if (mem_ready_i) begin
                    state_d = REFILL;
                end
            end
            // back to lookup, which then hits on the new line
            REFILL: begin
                if (mem_ready_i) begin
                    state_d = LOOKUP;
                end
            end
            HIT: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign in_hit      = (state_q == HIT);
    assign refill_done = (state_q == REFILL) && mem_ready_i;
    assign victim_word = victim_way_i ? rdata1_i : rdata0_i;

    // cpu side
    assign done_o  = in_hit;
    assign rdata_o = hit_way_i ? rdata1_i : rdata0_i;

    // memory side, stable while waiting for ready
    always_comb begin
        unique case (state_q)
            WBACK:   mem_op_o = MEM_WBACK;
            REFILL:  mem_op_o = MEM_REFILL;
            default: mem_op_o = MEM_NONE;
        endcase
    end

    assign mem_addr_o = (state_q == WBACK) ?
                        {victim_tag_i, index_o, {`DC_INDEX_LSB{1'b0}}} :
                        {tag_o, index_o, {`DC_INDEX_LSB{1'b0}}};
    assign mem_wdata_o = victim_word;

    // tag store updates
    assign fill_o      = refill_done;
    assign fill_way_o  = victim_way_i;
    assign touch_o     = in_hit;
    assign set_dirty_o = in_hit && req_write_i;
    assign use_way_o   = hit_way_i;

    // write hit merges cpu bytes, refill writes the whole word
    assign ram_we_o    = (in_hit && req_write_i) || refill_done;
    assign ram_way_o   = in_hit ? hit_way_i : victim_way_i;
    assign ram_wstrb_o = in_hit ? wstrb_i : {`DC_STRB_W{1'b1}};
    assign ram_wdata_o = in_hit ? wdata_i : mem_rdata_i;

endmodule

`default_nettype wire

//--- hdl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_top
    import dcache_pkg::*;
    import mem_bus_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   req_valid_i,
    input  wire                   req_write_i,
    input  wire [`DC_ADDR_W-1:0]  addr_i,
    input  wire [`DC_WORD_W-1:0]  wdata_i,
    input  wire [`DC_STRB_W-1:0]  wstrb_i,
    output logic [`DC_WORD_W-1:0] rdata_o,
    output logic                  done_o,
    output mem_op_e               mem_op_o,
    output logic [`DC_ADDR_W-1:0] mem_addr_o,
    output logic [`DC_WORD_W-1:0] mem_wdata_o,
    input  wire [`DC_WORD_W-1:0]  mem_rdata_i,
    input  wire                   mem_ready_i
);

    dc_index_t             index;
    dc_tag_t               tag;
    logic                  fill;
    dc_way_t               fill_way;
    logic                  set_dirty;
    logic                  touch;
    dc_way_t               use_way;
    logic                  hit;
    dc_way_t               hit_way;
    dc_way_t               victim_way;
    logic                  victim_dirty;
    dc_tag_t               victim_tag;
    logic                  ram_we;
    dc_way_t               ram_way;
    logic [`DC_STRB_W-1:0] ram_wstrb;
    logic [`DC_WORD_W-1:0] ram_wdata;
    logic [`DC_WORD_W-1:0] rdata0;
    logic [`DC_WORD_W-1:0] rdata1;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .req_valid_i    (req_valid_i),
        .req_write_i    (req_write_i),
        .addr_i         (addr_i),
        .wdata_i        (wdata_i),
        .wstrb_i        (wstrb_i),
        .rdata_o        (rdata_o),
        .done_o         (done_o),
        .mem_op_o       (mem_op_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_rdata_i    (mem_rdata_i),
        .mem_ready_i    (mem_ready_i),
        .fill_o         (fill),
        .fill_way_o     (fill_way),
        .set_dirty_o    (set_dirty),
        .touch_o        (touch),
        .use_way_o      (use_way),
        .index_o        (index),
        .tag_o          (tag),
        .ram_we_o       (ram_we),
        .ram_way_o      (ram_way),
        .ram_wstrb_o    (ram_wstrb),
        .ram_wdata_o    (ram_wdata),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag),
        .rdata0_i       (rdata0),
        .rdata1_i       (rdata1)
    );

    dcache_tag_store u_tag_store (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .index_i        (index),
        .tag_i          (tag),
        .fill_i         (fill),
        .fill_way_i     (fill_way),
        .set_dirty_i    (set_dirty),
        .touch_i        (touch),
        .use_way_i      (use_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    dcache_data_store u_data_store (
        .clk      (clk),
        .index_i  (index),
        .we_i     (ram_we),
        .way_i    (ram_way),
        .wstrb_i  (ram_wstrb),
        .wdata_i  (ram_wdata),
        .rdata0_o (rdata0),
        .rdata1_o (rdata1)
    );

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 20 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #10 clk_o = ~clk_o;
        end
    end

    // reset held low over the first two rising edges
    initial begin
        rst_n_o <= 1'b0;
        repeat (2) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/dcache_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module dcache_checker
    import mem_bus_pkg::*;
#(
    parameter logic [`DC_WORD_W-1:0] init_pattern = '0
)
(
    input  wire                  clk,
    input  wire                  rst_n_i,
    input  wire                  req_valid_i,
    input  wire                  req_write_i,
    input  wire [`DC_ADDR_W-1:0] addr_i,
    input  wire [`DC_WORD_W-1:0] wdata_i,
    input  wire [`DC_STRB_W-1:0] wstrb_i,
    input  wire [`DC_WORD_W-1:0] rdata_i,
    input  wire                  done_i,
    input  wire mem_op_e         mem_op_i,
    input  wire [`DC_ADDR_W-1:0] mem_addr_i,
    input  wire [`DC_WORD_W-1:0] mem_wdata_i,
    input  wire                  mem_ready_i,
    input  wire [1:0]            exp_refills_i,
    input  wire                  exp_wback_i,
    input  wire [`DC_ADDR_W-1:0] exp_wb_addr_i,
    output int                   errors_o,
    output int                   reads_o,
    output int                   writes_o,
    output int                   wbacks_o
);

    // golden memory, one entry per written byte
    logic [7:0] golden [logic [`DC_ADDR_W-1:0]];
    int         error_count = 0;
    int         read_count = 0;
    int         write_count = 0;
    int         wback_count = 0;
    int         cycle = 0;
    int         start_cycle = 0;
    int         req_refills = 0;
    int         req_wbacks = 0;
    logic       busy = 1'b0;
    logic       started = 1'b0;

    assign errors_o = error_count;
    assign reads_o  = read_count;
    assign writes_o = write_count;
    assign wbacks_o = wback_count;

    function automatic logic [`DC_ADDR_W-1:0] word_addr(input logic [`DC_ADDR_W-1:0] a);
        return {a[`DC_ADDR_W-1:`DC_INDEX_LSB], {`DC_INDEX_LSB{1'b0}}};
    endfunction

    // untouched bytes come from the address xor pattern
    function automatic logic [`DC_WORD_W-1:0] golden_word(input logic [`DC_ADDR_W-1:0] base);
        logic [`DC_WORD_W-1:0] word;
        word = {base, base} ^ init_pattern;
        for (int b = 0; b < `DC_STRB_W; b++) begin
            if (golden.exists(base + b)) begin
                word[b*8 +: 8] = golden[base + b];
            end
        end
        return word;
    endfunction

    task automatic flag_error(input string msg);
        error_count++;
        $display("CHECK FAILED @ %0t: %s", $time, msg);
    endtask

    task automatic check_wback();
        logic [`DC_WORD_W-1:0] expected;
        expected = golden_word(mem_addr_i);
        wback_count++;
        req_wbacks++;
        if (!exp_wback_i) begin
            flag_error($sformatf("unexpected write-back to 0x%08h", mem_addr_i));
        end else if (mem_addr_i != exp_wb_addr_i) begin
            flag_error($sformatf("write-back to 0x%08h, expected 0x%08h",
                                 mem_addr_i, exp_wb_addr_i));
        end
        if (req_refills != 0) begin
            flag_error("write-back came after the refill");
        end
        if (mem_wdata_i != expected) begin
            flag_error($sformatf("write-back data 0x%016h, expected 0x%016h",
                                 mem_wdata_i, expected));
        end
    endtask

    task automatic check_refill();
        req_refills++;
        if (mem_addr_i != word_addr(addr_i)) begin
            flag_error($sformatf("refill from 0x%08h, expected 0x%08h",
                                 mem_addr_i, word_addr(addr_i)));
        end
    endtask

    task automatic check_done();
        logic [`DC_WORD_W-1:0] expected;
        expected = golden_word(word_addr(addr_i));
        if (!busy) begin
            flag_error("done_o without a request");
        end
        if (req_write_i) begin
            write_count++;
            for (int b = 0; b < `DC_STRB_W; b++) begin
                if (wstrb_i[b]) begin
                    golden[word_addr(addr_i) + b] = wdata_i[b*8 +: 8];
                end
            end
        end else begin
            read_count++;
            if (rdata_i !== expected) begin
                flag_error($sformatf("read 0x%08h returned 0x%016h, expected 0x%016h",
                                     addr_i, rdata_i, expected));
            end
        end
        if (req_refills != int'(exp_refills_i)) begin
            flag_error($sformatf("0x%08h saw %0d refills, expected %0d",
                                 addr_i, req_refills, exp_refills_i));
        end
        if (req_wbacks != int'(exp_wback_i)) begin
            flag_error($sformatf("0x%08h saw %0d write-backs, expected %0d",
                                 addr_i, req_wbacks, exp_wback_i));
        end
        // a hit finishes 2 cycles after acceptance
        if (req_refills == 0 && req_wbacks == 0 && cycle - start_cycle != 2) begin
            flag_error($sformatf("hit on 0x%08h took %0d cycles", addr_i, cycle - start_cycle));
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n_i) begin
            cycle++;
            if (!started && !req_valid_i && (done_i || mem_op_i != MEM_NONE)) begin
                flag_error("done_o or mem_op_o active before the first request");
            end
            if (!busy && req_valid_i) begin
                busy        = 1'b1;
                started     = 1'b1;
                start_cycle = cycle;
                req_refills = 0;
                req_wbacks  = 0;
            end
            if (mem_ready_i && mem_op_i == MEM_WBACK) begin
                check_wback();
            end
            if (mem_ready_i && mem_op_i == MEM_REFILL) begin
                check_refill();
            end
            if (done_i) begin
                check_done();
                busy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defs.svh"

module tb_dcache
    import mem_bus_pkg::*;
();

    localparam logic [`DC_WORD_W-1:0] init_pattern = 64'h5a3c_96e1_0f87_c32d;
    localparam int cycles_per_row = 24;

    typedef enum logic [1:0] {
        ROW_READ,
        ROW_WRITE,
        ROW_RAND_WRITE
    } row_kind_e;

    typedef struct packed {
        row_kind_e             kind;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_WORD_W-1:0] wdata;
        logic [`DC_STRB_W-1:0] wstrb;
        logic [1:0]            refills;
        logic                  wback;
        logic [`DC_ADDR_W-1:0] wb_addr;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_write;
    logic [`DC_ADDR_W-1:0] addr;
    logic [`DC_WORD_W-1:0] wdata;
    logic [`DC_STRB_W-1:0] wstrb;
    logic [`DC_WORD_W-1:0] rdata;
    logic                  done;
    mem_op_e               mem_op;
    logic [`DC_ADDR_W-1:0] mem_addr;
    logic [`DC_WORD_W-1:0] mem_wdata;
    logic [`DC_WORD_W-1:0] mem_rdata;
    logic                  mem_ready;
    logic [1:0]            exp_refills;
    logic                  exp_wback;
    logic [`DC_ADDR_W-1:0] exp_wb_addr;
    int                    errors;
    int                    reads;
    int                    writes;
    int                    wbacks;

    row_t                  rows [$];
    integer                seed = 58700;
    int                    cycles = 0;
    int                    timeout_limit = 0;
    logic [`DC_WORD_W-1:0] model_mem [logic [`DC_ADDR_W-1:0]];

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    dcache_top UUT (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_write_i (req_write),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .wstrb_i     (wstrb),
        .rdata_o     (rdata),
        .done_o      (done),
        .mem_op_o    (mem_op),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata),
        .mem_ready_i (mem_ready)
    );

    dcache_checker #(
        .init_pattern (init_pattern)
    ) u_checker (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .req_valid_i   (req_valid),
        .req_write_i   (req_write),
        .addr_i        (addr),
        .wdata_i       (wdata),
        .wstrb_i       (wstrb),
        .rdata_i       (rdata),
        .done_i        (done),
        .mem_op_i      (mem_op),
        .mem_addr_i    (mem_addr),
        .mem_wdata_i   (mem_wdata),
        .mem_ready_i   (mem_ready),
        .exp_refills_i (exp_refills),
        .exp_wback_i   (exp_wback),
        .exp_wb_addr_i (exp_wb_addr),
        .errors_o      (errors),
        .reads_o       (reads),
        .writes_o      (writes),
        .wbacks_o      (wbacks)
    );

    function automatic logic [`DC_WORD_W-1:0] model_word(input logic [`DC_ADDR_W-1:0] a);
        if (model_mem.exists(a)) begin
            return model_mem[a];
        end
        return {a, a} ^ init_pattern;
    endfunction

    task automatic add_row(
        input row_kind_e             kind,
        input logic [`DC_ADDR_W-1:0] byte_addr,
        input logic [`DC_WORD_W-1:0] data,
        input logic [`DC_STRB_W-1:0] strb,
        input logic [1:0]            n_refill,
        input logic                  wb,
        input logic [`DC_ADDR_W-1:0] wb_addr
    );
        row_t r;
        r.kind    = kind;
        r.addr    = byte_addr;
        r.wdata   = data;
        r.wstrb   = strb;
        r.refills = n_refill;
        r.wback   = wb;
        r.wb_addr = wb_addr;
        rows.push_back(r);
    endtask

    task automatic fill_table();
        // cold read, then partial writes and repeat reads on the same line
        add_row(ROW_READ,       32'h0000_0104, 64'h0, 8'h00, 2'd1, 1'b0, 32'h0);
        add_row(ROW_WRITE,      32'h0000_0104, 64'h1122_3344_5566_7788, 8'h0f, 2'd0, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_0100, 64'h0, 8'h00, 2'd0, 1'b0, 32'h0);
        add_row(ROW_WRITE,      32'h0000_0104, 64'hdead_beef_cafe_f00d, 8'ha0, 2'd0, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_0104, 64'h0, 8'h00, 2'd0, 1'b0, 32'h0);
        // write miss allocates
        add_row(ROW_RAND_WRITE, 32'h0000_0180, 64'h0, 8'h00, 2'd1, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_0180, 64'h0, 8'h00, 2'd0, 1'b0, 32'h0);
        // index 5: dirty line evicted by the third tag
        add_row(ROW_RAND_WRITE, 32'h0000_0228, 64'h0, 8'h00, 2'd1, 1'b0, 32'h0);
        add_row(ROW_WRITE,      32'h0000_0228, 64'h0123_4567_89ab_cdef, 8'h3c, 2'd0, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_0428, 64'h0, 8'h00, 2'd1, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_0628, 64'h0, 8'h00, 2'd1, 1'b1, 32'h0000_0228);
        add_row(ROW_READ,       32'h0000_0228, 64'h0, 8'h00, 2'd1, 1'b0, 32'h0);
        // index 9: clean evictions follow the recently-used bit
        add_row(ROW_READ,       32'h0000_1048, 64'h0, 8'h00, 2'd1, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_2048, 64'h0, 8'h00, 2'd1, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_1048, 64'h0, 8'h00, 2'd0, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_3048, 64'h0, 8'h00, 2'd1, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_1048, 64'h0, 8'h00, 2'd0, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_2048, 64'h0, 8'h00, 2'd1, 1'b0, 32'h0);
        add_row(ROW_RAND_WRITE, 32'h0000_1048, 64'h0, 8'h00, 2'd0, 1'b0, 32'h0);
        add_row(ROW_READ,       32'h0000_1048, 64'h0, 8'h00, 2'd0, 1'b0, 32'h0);
    endtask

    initial begin : stimulus
        row_t        r;
        logic [31:0] rnd_hi;
        logic [31:0] rnd_lo;
        logic [31:0] rnd_strb;
        req_valid   <= 1'b0;
        req_write   <= 1'b0;
        addr        <= '0;
        wdata       <= '0;
        wstrb       <= '0;
        exp_refills <= '0;
        exp_wback   <= 1'b0;
        exp_wb_addr <= '0;
        fill_table();
        timeout_limit = rows.size() * cycles_per_row + 50;
        @(posedge rst_n);
        // a few idle cycles so the quiet outputs after reset are seen
        repeat (3) @(posedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            r = rows[i];
            if (r.kind == ROW_RAND_WRITE) begin
                rnd_hi   = $random(seed);
                rnd_lo   = $random(seed);
                rnd_strb = $random(seed);
                r.wdata  = {rnd_hi, rnd_lo};
                r.wstrb  = rnd_strb[`DC_STRB_W-1:0];
            end
            @(posedge clk);
            req_valid   <= 1'b1;
            req_write   <= (r.kind != ROW_READ);
            addr        <= r.addr;
            wdata       <= r.wdata;
            wstrb       <= r.wstrb;
            exp_refills <= r.refills;
            exp_wback   <= r.wback;
            exp_wb_addr <= r.wb_addr;
            do begin
                @(negedge clk);
            end while (!done);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        repeat (2) @(posedge clk);
        $display("summary: %0d reads, %0d writes, %0d write-backs, %0d errors",
                 reads, writes, wbacks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // memory answers after 1 to 4 cycles
    initial begin : memory_model
        mem_op_e               op;
        logic [`DC_ADDR_W-1:0] op_addr;
        logic [`DC_WORD_W-1:0] op_data;
        int                    rnd;
        int                    wait_cycles;
        mem_ready <= 1'b0;
        mem_rdata <= '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_op != MEM_NONE) begin
                op          = mem_op;
                op_addr     = mem_addr;
                op_data     = mem_wdata;
                rnd         = $random(seed);
                wait_cycles = 1 + (rnd & 3);
                repeat (wait_cycles) @(posedge clk);
                if (op == MEM_WBACK) begin
                    model_mem[op_addr] = op_data;
                end else begin
                    mem_rdata <= model_word(op_addr);
                end
                mem_ready <= 1'b1;
                @(posedge clk);
                mem_ready <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (timeout_limit > 0 && cycles >= timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("Regression failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/mem_bus_pkg.sv
hdl/dcache_tag_store.sv
hdl/dcache_data_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
sim/tb_clock_gen.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

//--- run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_dcache -Mdir obj_dir -o tb_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_dcache)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Regression passed$"; then
    exit 0
fi
echo "pass message not found"
exit 1
